/* verilog/sl_cfg_pkg.sv */
// Link-wide configuration
//  - flit data width
//  - NoC flit type shared by the request and response channels
//  - default lane count, beat divider and credit count
package sl_cfg_pkg;

  // Data bits carried by one NoC flit
  parameter int FlitDataSize = 16;

  // Flit as seen on the NoC side of the link
  typedef struct packed {
    logic                    valid;
    logic [FlitDataSize-1:0] data;
  } noc_flit_t;

  //////////////////////////////////////////////////
  // Defaults handed down by the top level
  //////////////////////////////////////////////////

  // Lanes in each direction
  parameter int DefNumLanes = 4;

  // clk_i cycles per beat, even and at least 2
  parameter int DefClkDiv = 4;

  // Credits per direction, also the receive FIFO depth
  parameter int DefNumCredits = 4;

endpackage : sl_cfg_pkg

/* verilog/sl_frame_pkg.sv */
// Link layer types
//  - channel header enum
//  - payload and frame structs, frame width
//  - physical layer transmit states
package sl_frame_pkg;

  // Header bit that tells the two NoC channels apart
  typedef enum logic {
    CHAN_REQ = 1'b0,
    CHAN_RSP = 1'b1
  } noc_chan_e;

  typedef struct packed {
    noc_chan_e                            hdr;
    logic [sl_cfg_pkg::FlitDataSize-1:0]  flit_data;
  } payload_t;

  // One frame on the wire, start is always set
  typedef struct packed {
    logic     start;
    logic     data_valid;
    logic     credit_ret;
    payload_t payload;
  } frame_t;

  parameter int FrameBits = $bits(frame_t);

  typedef enum logic {
    TX_IDLE  = 1'b0,
    TX_SHIFT = 1'b1
  } phy_tx_state_e;

endpackage : sl_frame_pkg

/* verilog/sl_credit_fifo.sv */
// Receive FIFO of the data link
//  - circular buffer, one entry per credit
//  - head visible one cycle after a write, pop pulse per accepted read
`timescale 1ns/1ps

module sl_credit_fifo #(
  parameter int NumCredits = 4
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   wr_valid_i,
  input  sl_frame_pkg::payload_t wr_data_i,
  output logic                   rd_valid_o,
  output sl_frame_pkg::payload_t rd_data_o,
  input  logic                   rd_ready_i,
  output logic                   pop_o
);

  import sl_frame_pkg::*;

  localparam int PtrW = (NumCredits > 1) ? $clog2(NumCredits) : 1;
  localparam int CntW = $clog2(NumCredits + 1);

  payload_t        mem_q [NumCredits];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;

  assign rd_valid_o = count_q != '0;
  assign rd_data_o  = mem_q[rd_ptr_q];
  assign pop_o      = rd_valid_o && rd_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(NumCredits - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_o) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(NumCredits - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(wr_valid_i) - CntW'(pop_o);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (wr_valid_i) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

endmodule : sl_credit_fifo

/* verilog/sl_data_link.sv */
// Data link layer
//  - transmit frame register with credit check
//  - credit counter and owed-credit bookkeeping
//  - receive FIFO for incoming payloads
`timescale 1ns/1ps

module sl_data_link #(
  parameter int NumCredits = 4
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // From and to the bridge
  input  sl_frame_pkg::payload_t tx_payload_i,
  input  logic                   tx_valid_i,
  output logic                   tx_ready_o,
  output sl_frame_pkg::payload_t rx_payload_o,
  output logic                   rx_valid_o,
  input  logic                   rx_ready_i,
  // To phy_tx
  output sl_frame_pkg::frame_t   frame_o,
  output logic                   frame_valid_o,
  input  logic                   frame_ready_i,
  // From phy_rx
  input  sl_frame_pkg::frame_t   frame_rx_i,
  input  logic                   frame_rx_valid_i
);

  import sl_frame_pkg::*;

  localparam int CntW = $clog2(NumCredits + 1);

  logic [CntW-1:0] credit_q;
  logic [CntW-1:0] owed_q;
  frame_t          frame_q;
  logic            frame_valid_q;
  logic            send_data;
  logic            owe;
  logic            load;
  logic            credit_in;
  logic            pop;

  //////////////////////////////////////////////////
  // Transmit side
  //////////////////////////////////////////////////

  assign tx_ready_o = !frame_valid_q && (credit_q != '0);
  assign send_data  = tx_valid_i && tx_ready_o;
  assign owe        = owed_q != '0;

  // A frame carries data, a returned credit, or both
  assign load       = !frame_valid_q && (send_data || owe);
  assign credit_in  = frame_rx_valid_i && frame_rx_i.credit_ret;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      frame_valid_q <= 1'b0;
      credit_q      <= CntW'(NumCredits);
      owed_q        <= '0;
    end else begin
      if (load) begin
        frame_valid_q <= 1'b1;
      end else if (frame_ready_i) begin
        frame_valid_q <= 1'b0;
      end
      credit_q <= credit_q - CntW'(send_data) + CntW'(credit_in);
      owed_q   <= owed_q + CntW'(pop) - CntW'(load && owe);
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      frame_q.start      <= 1'b1;
      frame_q.data_valid <= send_data;
      frame_q.credit_ret <= owe;
      frame_q.payload    <= tx_payload_i;
    end
  end

  assign frame_o       = frame_q;
  assign frame_valid_o = frame_valid_q;

  //////////////////////////////////////////////////
  // Receive side
  //////////////////////////////////////////////////

  // Credits guarantee room, so data frames are written unconditionally
  sl_credit_fifo #(
    .NumCredits ( NumCredits )
  ) i_rx_fifo (
    .clk_i      ( clk_i                                      ),
    .reset_i    ( reset_i                                    ),
    .wr_valid_i ( frame_rx_valid_i && frame_rx_i.data_valid  ),
    .wr_data_i  ( frame_rx_i.payload                         ),
    .rd_valid_o ( rx_valid_o                                 ),
    .rd_data_o  ( rx_payload_o                               ),
    .rd_ready_i ( rx_ready_i                                 ),
    .pop_o      ( pop                                        )
  );

endmodule : sl_data_link

/* verilog/sl_noc_bridge.sv */
// NoC bridge
//  - round-robin merge of request and response flits into one payload stream
//  - split of received payloads by header onto the two output channels
`timescale 1ns/1ps

module sl_noc_bridge (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // NoC side
  input  sl_cfg_pkg::noc_flit_t  req_i,
  input  sl_cfg_pkg::noc_flit_t  rsp_i,
  output logic                   req_ready_o,
  output logic                   rsp_ready_o,
  output sl_cfg_pkg::noc_flit_t  req_o,
  output sl_cfg_pkg::noc_flit_t  rsp_o,
  input  logic                   req_ready_i,
  input  logic                   rsp_ready_i,
  // Data link side
  output sl_frame_pkg::payload_t tx_payload_o,
  output logic                   tx_valid_o,
  input  logic                   tx_ready_i,
  input  sl_frame_pkg::payload_t rx_payload_i,
  input  logic                   rx_valid_i,
  output logic                   rx_ready_o
);

  import sl_frame_pkg::*;

  noc_chan_e last_grant_q;
  logic      sel_rsp;
  logic      sel_req;

  //////////////////////////////////////////////////
  // Transmit merge
  //////////////////////////////////////////////////

  // Response wins when alone, or when request was served last
  assign sel_rsp = rsp_i.valid && (!req_i.valid || last_grant_q == CHAN_REQ);
  assign sel_req = req_i.valid && !sel_rsp;

  assign tx_valid_o             = req_i.valid || rsp_i.valid;
  assign tx_payload_o.hdr       = sel_rsp ? CHAN_RSP : CHAN_REQ;
  assign tx_payload_o.flit_data = sel_rsp ? rsp_i.data : req_i.data;

  // Only the granted channel sees ready while the other one waits
  assign req_ready_o = tx_ready_i && !sel_rsp;
  assign rsp_ready_o = tx_ready_i && !sel_req;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_grant_q <= CHAN_RSP;
    end else if (tx_valid_o && tx_ready_i) begin
      last_grant_q <= tx_payload_o.hdr;
    end
  end

  //////////////////////////////////////////////////
  // Receive split
  //////////////////////////////////////////////////

  assign req_o.valid = rx_valid_i && (rx_payload_i.hdr == CHAN_REQ);
  assign req_o.data  = rx_payload_i.flit_data;
  assign rsp_o.valid = rx_valid_i && (rx_payload_i.hdr == CHAN_RSP);
  assign rsp_o.data  = rx_payload_i.flit_data;

  // Head of the FIFO waits on whichever channel it belongs to
  assign rx_ready_o = (rx_payload_i.hdr == CHAN_REQ) ? req_ready_i : rsp_ready_i;

endmodule : sl_noc_bridge

/* verilog/sl_phy_tx.sv */
// Physical layer transmitter
//  - FSM that takes one frame at a time from the data link
//  - beat serializer over NumLanes lanes and forwarded clock
`timescale 1ns/1ps

module sl_phy_tx #(
  parameter int NumLanes = 4,
  parameter int ClkDiv   = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  sl_frame_pkg::frame_t frame_i,
  input  logic                 frame_valid_i,
  output logic                 frame_ready_o,
  output logic                 ddr_rcv_clk_o,
  output logic [NumLanes-1:0]  ddr_o
);

  import sl_frame_pkg::*;

  localparam int Beats   = (FrameBits + NumLanes - 1) / NumLanes;
  localparam int PadBits = Beats * NumLanes;
  localparam int BeatW   = (Beats > 1) ? $clog2(Beats) : 1;
  localparam int DivW    = $clog2(ClkDiv);

  phy_tx_state_e        state_q;
  logic [BeatW-1:0]     beat_q;
  logic [DivW-1:0]      div_q;
  logic [PadBits-1:0]   shift_q;
  logic [FrameBits-1:0] frame_bits;
  logic [FrameBits-1:0] frame_rot;
  logic                 beat_end;

  // Start bit moves to bit 0 so it lands on lane 0 of the first beat
  assign frame_bits = frame_i;
  assign frame_rot  = {frame_bits[FrameBits-2:0], frame_bits[FrameBits-1]};

  assign frame_ready_o = (state_q == TX_IDLE);
  assign beat_end      = (div_q == DivW'(ClkDiv - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= TX_IDLE;
      beat_q  <= '0;
      div_q   <= '0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (frame_valid_i) begin
            state_q <= TX_SHIFT;
            beat_q  <= '0;
            div_q   <= '0;
          end
        end
        TX_SHIFT: begin
          if (beat_end) begin
            div_q  <= '0;
            beat_q <= beat_q + 1'b1;
            if (beat_q == BeatW'(Beats - 1)) begin
              state_q <= TX_IDLE;
            end
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == TX_IDLE && frame_valid_i) begin
      shift_q <= PadBits'(frame_rot);
    end else if (state_q == TX_SHIFT && beat_end) begin
      shift_q <= shift_q >> NumLanes;
    end
  end

  // Clock high for the first half of each beat, lanes quiet when idle
  assign ddr_rcv_clk_o = (state_q == TX_SHIFT) && (div_q < DivW'(ClkDiv / 2));
  assign ddr_o         = (state_q == TX_SHIFT) ? shift_q[NumLanes-1:0] : '0;

endmodule : sl_phy_tx

/* verilog/sl_phy_rx.sv */
// Physical layer receiver
//  - falling-edge detector on the forwarded clock
//  - beat deserializer that starts on the start bit, abort on a lost clock
`timescale 1ns/1ps

module sl_phy_rx #(
  parameter int NumLanes = 4,
  parameter int ClkDiv   = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 ddr_rcv_clk_i,
  input  logic [NumLanes-1:0]  ddr_i,
  output sl_frame_pkg::frame_t frame_rx_o,
  output logic                 frame_rx_valid_o
);

  import sl_frame_pkg::*;

  localparam int Beats    = (FrameBits + NumLanes - 1) / NumLanes;
  localparam int PadBits  = Beats * NumLanes;
  localparam int BeatW    = (Beats > 1) ? $clog2(Beats) : 1;
  localparam int GapLimit = 2 * ClkDiv;
  localparam int GapW     = $clog2(GapLimit + 1);

  logic                        rcv_clk_q;
  logic                        busy_q;
  logic                        valid_q;
  logic [BeatW-1:0]            beat_q;
  logic [GapW-1:0]             gap_q;
  logic [PadBits-1:0]          shift_q;
  logic [PadBits+NumLanes-1:0] shift_in;
  logic [FrameBits-1:0]        frame_bits;
  logic                        fall;
  logic                        capture;

  assign fall     = rcv_clk_q && !ddr_rcv_clk_i;
  // Idle falls without start on lane 0 are ignored
  assign capture  = fall && (busy_q || ddr_i[0]);
  assign shift_in = {ddr_i, shift_q};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rcv_clk_q <= 1'b0;
      busy_q    <= 1'b0;
      valid_q   <= 1'b0;
      beat_q    <= '0;
      gap_q     <= '0;
    end else begin
      rcv_clk_q <= ddr_rcv_clk_i;
      valid_q   <= 1'b0;
      if (fall) begin
        gap_q <= '0;
      end else if (busy_q) begin
        gap_q <= gap_q + 1'b1;
      end
      if (capture) begin
        if (beat_q == BeatW'(Beats - 1)) begin
          busy_q  <= 1'b0;
          beat_q  <= '0;
          valid_q <= 1'b1;
        end else begin
          busy_q <= 1'b1;
          beat_q <= beat_q + 1'b1;
        end
      end else if (busy_q && gap_q == GapW'(GapLimit)) begin
        // Forwarded clock stopped mid-frame, drop the partial frame
        busy_q <= 1'b0;
        beat_q <= '0;
        gap_q  <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      shift_q <= shift_in[PadBits+NumLanes-1:NumLanes];
    end
  end

  // Undo the start bit rotation of the transmitter
  assign frame_bits       = {shift_q[0], shift_q[FrameBits-1:1]};
  assign frame_rx_o       = frame_t'(frame_bits);
  assign frame_rx_valid_o = valid_q;

endmodule : sl_phy_rx

/* verilog/serial_link.sv */
// Serial link top level
//  - NoC bridge, data link and physical layer transmitter and receiver
`timescale 1ns/1ps

module serial_link #(
  parameter int NumLanes   = sl_cfg_pkg::DefNumLanes,
  parameter int ClkDiv     = sl_cfg_pkg::DefClkDiv,
  parameter int NumCredits = sl_cfg_pkg::DefNumCredits
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  sl_cfg_pkg::noc_flit_t req_i,
  input  sl_cfg_pkg::noc_flit_t rsp_i,
  output logic                  req_ready_o,
  output logic                  rsp_ready_o,
  output sl_cfg_pkg::noc_flit_t req_o,
  output sl_cfg_pkg::noc_flit_t rsp_o,
  input  logic                  req_ready_i,
  input  logic                  rsp_ready_i,
  input  logic                  ddr_rcv_clk_i,
  output logic                  ddr_rcv_clk_o,
  input  logic [NumLanes-1:0]   ddr_i,
  output logic [NumLanes-1:0]   ddr_o
);

  import sl_frame_pkg::*;

  payload_t tx_payload, rx_payload;
  logic     tx_valid, tx_ready, rx_valid, rx_ready;
  frame_t   frame, frame_rx;
  logic     frame_valid, frame_ready, frame_rx_valid;

  //////////////////////////////////////////////////
  // NoC bridge
  //////////////////////////////////////////////////

  sl_noc_bridge i_noc_bridge (
    .clk_i        ( clk_i       ),
    .reset_i      ( reset_i     ),
    .req_i        ( req_i       ),
    .rsp_i        ( rsp_i       ),
    .req_ready_o  ( req_ready_o ),
    .rsp_ready_o  ( rsp_ready_o ),
    .req_o        ( req_o       ),
    .rsp_o        ( rsp_o       ),
    .req_ready_i  ( req_ready_i ),
    .rsp_ready_i  ( rsp_ready_i ),
    .tx_payload_o ( tx_payload  ),
    .tx_valid_o   ( tx_valid    ),
    .tx_ready_i   ( tx_ready    ),
    .rx_payload_i ( rx_payload  ),
    .rx_valid_i   ( rx_valid    ),
    .rx_ready_o   ( rx_ready    )
  );

  //////////////////////////////////////////////////
  // Data link
  //////////////////////////////////////////////////

  sl_data_link #(
    .NumCredits ( NumCredits )
  ) i_data_link (
    .clk_i            ( clk_i          ),
    .reset_i          ( reset_i        ),
    .tx_payload_i     ( tx_payload     ),
    .tx_valid_i       ( tx_valid       ),
    .tx_ready_o       ( tx_ready       ),
    .rx_payload_o     ( rx_payload     ),
    .rx_valid_o       ( rx_valid       ),
    .rx_ready_i       ( rx_ready       ),
    .frame_o          ( frame          ),
    .frame_valid_o    ( frame_valid    ),
    .frame_ready_i    ( frame_ready    ),
    .frame_rx_i       ( frame_rx       ),
    .frame_rx_valid_i ( frame_rx_valid )
  );

  //////////////////////////////////////////////////
  // Physical layer
  //////////////////////////////////////////////////

  sl_phy_tx #(
    .NumLanes ( NumLanes ),
    .ClkDiv   ( ClkDiv   )
  ) i_phy_tx (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .frame_i       ( frame         ),
    .frame_valid_i ( frame_valid   ),
    .frame_ready_o ( frame_ready   ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o ),
    .ddr_o         ( ddr_o         )
  );

  sl_phy_rx #(
    .NumLanes ( NumLanes ),
    .ClkDiv   ( ClkDiv   )
  ) i_phy_rx (
    .clk_i            ( clk_i          ),
    .reset_i          ( reset_i        ),
    .ddr_rcv_clk_i    ( ddr_rcv_clk_i  ),
    .ddr_i            ( ddr_i          ),
    .frame_rx_o       ( frame_rx       ),
    .frame_rx_valid_o ( frame_rx_valid )
  );

endmodule : serial_link

/* tb/sl_checker.sv */
// Testbench checker
//  - per-channel scoreboards fed by accepted input flits
//  - quiet outputs during and just after reset
//  - accepted flit limit while both outputs are stalled
`timescale 1ns/1ps

module sl_checker #(
  parameter int NumLanes   = 4,
  parameter int NumCredits = 4
) (
  input logic                  clk_i,
  input logic                  reset_i,
  input sl_cfg_pkg::noc_flit_t req_in_i,
  input logic                  req_in_ready_i,
  input sl_cfg_pkg::noc_flit_t rsp_in_i,
  input logic                  rsp_in_ready_i,
  input sl_cfg_pkg::noc_flit_t req_out_i,
  input logic                  req_out_ready_i,
  input sl_cfg_pkg::noc_flit_t rsp_out_i,
  input logic                  rsp_out_ready_i,
  input logic [NumLanes-1:0]   lanes_i,
  input logic                  lane_clk_i
);

  import sl_cfg_pkg::*;

  logic [FlitDataSize-1:0] req_exp_q[$];
  logic [FlitDataSize-1:0] rsp_exp_q[$];
  int   value_errs    = 0;
  int   proto_errs    = 0;
  int   reset_cycles  = 0;
  int   stall_accepts = 0;
  logic after_reset   = 1'b0;
  logic stall_flagged = 1'b0;

  function automatic int outstanding();
    return req_exp_q.size() + rsp_exp_q.size();
  endfunction

  task automatic expect_zero(input string name, input logic [31:0] got);
    if (got !== '0) begin
      $display("FAILED at %0t: %s expected 0, got %0h", $time, name, got);
      value_errs++;
    end
  endtask

  task automatic verify_quiet();
    expect_zero("req_o.valid", 32'(req_out_i.valid));
    expect_zero("rsp_o.valid", 32'(rsp_out_i.valid));
    expect_zero("ddr_o", 32'(lanes_i));
    expect_zero("ddr_rcv_clk_o", 32'(lane_clk_i));
  endtask

  // Head of the matching scoreboard must equal the delivered data
  task automatic score_delivery(input logic is_rsp, input logic [FlitDataSize-1:0] got);
    logic [FlitDataSize-1:0] exp;
    string                   name;
    name = is_rsp ? "rsp_o.data" : "req_o.data";
    if ((is_rsp && rsp_exp_q.size() == 0) || (!is_rsp && req_exp_q.size() == 0)) begin
      $display("ERROR at %0t: %s delivered a flit that was never accepted", $time, name);
      proto_errs++;
    end else begin
      if (is_rsp) begin
        exp = rsp_exp_q.pop_front();
      end else begin
        exp = req_exp_q.pop_front();
      end
      if (got !== exp) begin
        $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, got);
        value_errs++;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      // Registers are unknown before the first reset edge
      if (reset_cycles > 0) begin
        verify_quiet();
      end
      reset_cycles++;
      after_reset   = 1'b1;
      stall_accepts = 0;
    end else begin
      if (after_reset) begin
        verify_quiet();
        after_reset = 1'b0;
      end
      if (req_in_i.valid && req_in_ready_i) begin
        req_exp_q.push_back(req_in_i.data);
      end
      if (rsp_in_i.valid && rsp_in_ready_i) begin
        rsp_exp_q.push_back(rsp_in_i.data);
      end
      if (req_out_i.valid && req_out_ready_i) begin
        score_delivery(1'b0, req_out_i.data);
      end
      if (rsp_out_i.valid && rsp_out_ready_i) begin
        score_delivery(1'b1, rsp_out_i.data);
      end

      ////////////////////////////////////////////////
      // Credit limit while both outputs stall
      ////////////////////////////////////////////////
      if (!req_out_ready_i && !rsp_out_ready_i) begin
        if (req_in_i.valid && req_in_ready_i) begin
          stall_accepts++;
        end
        if (rsp_in_i.valid && rsp_in_ready_i) begin
          stall_accepts++;
        end
        if (stall_accepts > NumCredits + 1 && !stall_flagged) begin
          $display("ERROR at %0t: %0d flits accepted while both outputs were stalled",
                   $time, stall_accepts);
          proto_errs++;
          stall_flagged = 1'b1;
        end
      end else begin
        stall_accepts = 0;
        stall_flagged = 1'b0;
      end
    end
  end

  task automatic finish_checks(output int total);
    if (req_exp_q.size() != 0) begin
      $display("ERROR: %0d request flits were accepted but never delivered", req_exp_q.size());
      proto_errs++;
    end
    if (rsp_exp_q.size() != 0) begin
      $display("ERROR: %0d response flits were accepted but never delivered", rsp_exp_q.size());
      proto_errs++;
    end
    total = value_errs + proto_errs;
    $display("Checks done: %0d errors (%0d value mismatches, %0d protocol errors)",
             total, value_errs, proto_errs);
  endtask

endmodule : sl_checker

/* tb/tb_serial_link.sv */
// Serial link testbench
//  - clock, reset and lane loopback around the DUT
//  - stimulus vectors from the stim file fed through per-channel queues
//  - watchdog sized from the vector count and the frame length
`timescale 1ns/1ps

module tb_serial_link;

  import sl_cfg_pkg::*;

  localparam int NumLanes   = DefNumLanes;
  localparam int ClkDiv     = DefClkDiv;
  localparam int NumCredits = DefNumCredits;
  localparam int Beats      = (sl_frame_pkg::FrameBits + NumLanes - 1) / NumLanes;
  localparam int NumVectors = 20;
  localparam int VecWords   = 7;
  localparam int ClkPeriod  = 40;
  localparam int TimeoutNs  = NumVectors * 4 * Beats * ClkDiv * ClkPeriod;

  logic                    clk;
  logic                    reset;
  noc_flit_t               req_in;
  noc_flit_t               rsp_in;
  noc_flit_t               req_out;
  noc_flit_t               rsp_out;
  logic                    req_in_ready;
  logic                    rsp_in_ready;
  logic                    req_out_ready;
  logic                    rsp_out_ready;
  logic [NumLanes-1:0]     lanes;
  logic                    lane_clk;
  logic                    req_taken;
  logic                    rsp_taken;
  logic [FlitDataSize-1:0] stim_mem [NumVectors*VecWords];
  logic [FlitDataSize-1:0] req_pend_q[$];
  logic [FlitDataSize-1:0] rsp_pend_q[$];
  int                      total_errors;

  // Lanes and forwarded clock loop straight back
  serial_link #(
    .NumLanes   ( NumLanes   ),
    .ClkDiv     ( ClkDiv     ),
    .NumCredits ( NumCredits )
  ) dut_i (
    .clk_i         ( clk           ),
    .reset_i       ( reset         ),
    .req_i         ( req_in        ),
    .rsp_i         ( rsp_in        ),
    .req_ready_o   ( req_in_ready  ),
    .rsp_ready_o   ( rsp_in_ready  ),
    .req_o         ( req_out       ),
    .rsp_o         ( rsp_out       ),
    .req_ready_i   ( req_out_ready ),
    .rsp_ready_i   ( rsp_out_ready ),
    .ddr_rcv_clk_i ( lane_clk      ),
    .ddr_rcv_clk_o ( lane_clk      ),
    .ddr_i         ( lanes         ),
    .ddr_o         ( lanes         )
  );

  sl_checker #(
    .NumLanes   ( NumLanes   ),
    .NumCredits ( NumCredits )
  ) check_inst (
    .clk_i           ( clk           ),
    .reset_i         ( reset         ),
    .req_in_i        ( req_in        ),
    .req_in_ready_i  ( req_in_ready  ),
    .rsp_in_i        ( rsp_in        ),
    .rsp_in_ready_i  ( rsp_in_ready  ),
    .req_out_i       ( req_out       ),
    .req_out_ready_i ( req_out_ready ),
    .rsp_out_i       ( rsp_out       ),
    .rsp_out_ready_i ( rsp_out_ready ),
    .lanes_i         ( lanes         ),
    .lane_clk_i      ( lane_clk      )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Handshakes seen at the rising edge are consumed at the next falling edge
  always @(posedge clk) begin
    req_taken <= req_in.valid && req_in_ready;
    rsp_taken <= rsp_in.valid && rsp_in_ready;
  end

  task automatic offer_flits();
    logic [31:0] rnd;
    if (req_taken) begin
      req_in.valid = 1'b0;
    end
    if (!req_in.valid) begin
      rnd         = $urandom;
      req_in.data = rnd[FlitDataSize-1:0];
      if (req_pend_q.size() > 0) begin
        req_in.valid = 1'b1;
        req_in.data  = req_pend_q.pop_front();
      end
    end
    if (rsp_taken) begin
      rsp_in.valid = 1'b0;
    end
    if (!rsp_in.valid) begin
      rnd         = $urandom;
      rsp_in.data = rnd[FlitDataSize-1:0];
      if (rsp_pend_q.size() > 0) begin
        rsp_in.valid = 1'b1;
        rsp_in.data  = rsp_pend_q.pop_front();
      end
    end
  endtask

  initial begin
    logic [31:0] seed_draw;
    int          base;
    reset         = 1'b1;
    req_in        = '0;
    rsp_in        = '0;
    req_out_ready = 1'b0;
    rsp_out_ready = 1'b0;
    seed_draw     = $urandom(14);
    $readmemh("tb/sl_stim.txt", stim_mem);
    if ($isunknown(stim_mem[NumVectors*VecWords-1])) begin
      $display("ERROR: stimulus file tb/sl_stim.txt is missing or incomplete");
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      for (int v = 0; v < NumVectors; v++) begin
        @(negedge clk);
        base          = v * VecWords;
        req_out_ready = stim_mem[base + 4][0];
        rsp_out_ready = stim_mem[base + 5][0];
        if (stim_mem[base][0]) begin
          req_pend_q.push_back(stim_mem[base + 1]);
        end
        if (stim_mem[base + 2][0]) begin
          rsp_pend_q.push_back(stim_mem[base + 3]);
        end
        offer_flits();
        repeat (int'(stim_mem[base + 6])) begin
          @(negedge clk);
          offer_flits();
        end
      end

      // Drain everything that is still queued or in flight
      @(negedge clk);
      req_out_ready = 1'b1;
      rsp_out_ready = 1'b1;
      offer_flits();
      while (req_pend_q.size() > 0 || rsp_pend_q.size() > 0 || req_in.valid || rsp_in.valid
             || check_inst.outstanding() > 0) begin
        @(negedge clk);
        offer_flits();
      end
      repeat (2 * Beats * ClkDiv) @(negedge clk);

      check_inst.finish_checks(total_errors);
      if (total_errors == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

  initial begin
    #(TimeoutNs);
    $display("ERROR: watchdog expired after %0d ns, the link stopped delivering flits",
             TimeoutNs);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : tb_serial_link

/* tb/sl_stim.txt */
// Columns (hex): req_valid req_data rsp_valid rsp_data req_o_ready rsp_o_ready hold_cycles
// Each vector is applied on a falling edge and kept for hold_cycles more cycles
1 1001 0 0000 1 1 02
1 1002 0 0000 1 1 02
1 1003 0 0000 1 1 04
0 0000 1 2001 1 1 02
1 1004 1 2002 1 1 04
1 1005 1 2003 1 1 04
0 0000 1 2004 1 1 08
// Both outputs stalled, credits run out
1 1006 1 2005 0 0 20
1 1007 1 2006 0 0 20
1 1008 1 2007 0 0 40
0 0000 0 0000 0 0 20
// Response side still blocked, head of line may hold requests too
0 0000 0 0000 1 0 30
0 0000 0 0000 1 1 10
1 a5a5 0 0000 1 1 01
0 0000 1 5a5a 1 1 01
1 ffff 1 0000 0 1 08
1 0000 1 ffff 1 1 08
1 7e81 1 8001 1 0 08
1 1234 1 4321 1 1 04
1 beef 1 cafe 1 1 02

/* list.f */
verilog/sl_cfg_pkg.sv
verilog/sl_frame_pkg.sv
verilog/sl_credit_fifo.sv
verilog/sl_data_link.sv
verilog/sl_noc_bridge.sv
verilog/sl_phy_tx.sv
verilog/sl_phy_rx.sv
verilog/serial_link.sv
tb/sl_checker.sv
tb/tb_serial_link.sv

/* Makefile */
# Verilator build and run for the serial link testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_link
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps

SRCS := $(filter-out +%,$(shell cat list.f))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f list.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "TESTBENCH PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
